//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rvm_unit
FILELIST  ?= rvm_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/iter_multiplier.sv
`timescale 1ns/1ps

module iter_multiplier
    import rvm_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            start_i,
    input  mul_ctrl_t       ctrl_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    output logic            busy_o,
    output logic            done_o,
    output logic [XLEN-1:0] result_o
);

    mul_state_e             state;
    logic signed [XLEN:0]   multiplicand;   // One extra bit for the sign
    logic signed [XLEN:0]   multiplier;
    logic                   is_high;
    logic signed [2*XLEN+1:0] product;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= MUL_IDLE;
        end else begin
            case (state)
                MUL_IDLE: if (start_i && ctrl_i.is_mul) state <= MUL_EXEC;
                MUL_EXEC: state <= MUL_IDLE;
                default:  state <= MUL_IDLE;
            endcase
        end
    end

    // Sign or zero extension of both operands
    always_ff @(posedge clk_i) begin
        if (state == MUL_IDLE && start_i && ctrl_i.is_mul) begin
            multiplicand <= {ctrl_i.src1_signed && src1_i[XLEN-1], src1_i};
            multiplier   <= {ctrl_i.src2_signed && src2_i[XLEN-1], src2_i};
            is_high      <= ctrl_i.is_high;
        end
    end

    assign product = multiplicand * multiplier;

    assign busy_o   = (state == MUL_EXEC);
    assign done_o   = (state == MUL_EXEC);  // Result leaves in the same cycle
    assign result_o = is_high ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

endmodule

//--- rtl/muldiv_cmd_decode.sv
`timescale 1ns/1ps

module muldiv_cmd_decode
    import rvm_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            cmd_valid_i,
    input  funct3_t         cmd_funct3_i,
    input  logic [XLEN-1:0] cmd_src1_i,
    input  logic [XLEN-1:0] cmd_src2_i,
    input  logic            busy_i,
    input  logic            pending_i,
    output logic            cmd_ready_o,
    output logic            start_o,
    output logic [XLEN-1:0] src1_o,
    output logic [XLEN-1:0] src2_o,
    output mul_ctrl_t       mul_ctrl_o,
    output div_ctrl_t       div_ctrl_o
);

    logic       start_q;
    logic       accept;
    muldiv_op_e op;
    mul_ctrl_t  mul_ctrl_d;
    div_ctrl_t  div_ctrl_d;

    // Only one command in flight anywhere in the unit
    assign cmd_ready_o = !start_q && !busy_i && !pending_i;
    assign accept      = cmd_valid_i && cmd_ready_o;

    assign op = muldiv_op_e'(cmd_funct3_i);

    // Sign and half selection per operation
    always_comb begin
        mul_ctrl_d.is_mul      = !cmd_funct3_i[2];
        mul_ctrl_d.src1_signed = (op == OP_MULH) || (op == OP_MULHSU);
        mul_ctrl_d.src2_signed = (op == OP_MULH);
        mul_ctrl_d.is_high     = (op == OP_MULH) || (op == OP_MULHSU) || (op == OP_MULHU);

        div_ctrl_d.is_div    = cmd_funct3_i[2];
        div_ctrl_d.is_signed = (op == OP_DIV) || (op == OP_REM);
        div_ctrl_d.is_rem    = (op == OP_REM) || (op == OP_REMU);
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            start_q    <= 1'b0;
            mul_ctrl_o <= '0;
            div_ctrl_o <= '0;
        end else begin
            start_q <= accept;  // One-cycle pulse
            if (accept) begin
                mul_ctrl_o <= mul_ctrl_d;
                div_ctrl_o <= div_ctrl_d;
            end
        end
    end

    // Operand capture
    always_ff @(posedge clk_i) begin
        if (accept) begin
            src1_o <= cmd_src1_i;
            src2_o <= cmd_src2_i;
        end
    end

    assign start_o = start_q;

    // Arithmetic units must both be idle when a start goes out
    a_start_not_busy: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) start_o |-> !busy_i
    );

endmodule

//--- rtl/muldiv_response.sv
`timescale 1ns/1ps

module muldiv_response
    import rvm_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            mul_done_i,
    input  logic [XLEN-1:0] mul_result_i,
    input  logic            div_done_i,
    input  logic [XLEN-1:0] div_result_i,
    input  logic            rsp_ready_i,
    output logic            rsp_valid_o,
    output logic [XLEN-1:0] rsp_result_o,
    output logic            pending_o
);

    logic            valid_q;
    logic [XLEN-1:0] result_q;
    logic            any_done;

    assign any_done = mul_done_i || div_done_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (any_done) begin
            valid_q <= 1'b1;
        end else if (valid_q && rsp_ready_i) begin
            valid_q <= 1'b0;  // Consumed
        end
    end

    // Result held until the consuming edge
    always_ff @(posedge clk_i) begin
        if (any_done) begin
            result_q <= mul_done_i ? mul_result_i : div_result_i;
        end
    end

    assign rsp_valid_o  = valid_q;
    assign rsp_result_o = result_q;
    assign pending_o    = valid_q;  // Blocks new commands

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    a_single_done: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(mul_done_i && div_done_i)
    );

    a_hold_result: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_result_o))
    );

endmodule

//--- rtl/restoring_divider.sv
`timescale 1ns/1ps

module restoring_divider
    import rvm_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            start_i,
    input  div_ctrl_t       ctrl_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    output logic            busy_o,
    output logic            done_o,
    output logic [XLEN-1:0] result_o
);

    localparam int CNT_W = $clog2(XLEN);

    div_state_e       state;
    logic [CNT_W-1:0] step_cnt;
    logic [XLEN-1:0]  remainder;
    logic [XLEN-1:0]  quotient;
    logic [XLEN-1:0]  divisor;
    logic             dividend_neg;
    logic             divisor_neg;
    logic             quo_neg;      // Operand signs differ
    logic             rem_neg;      // Follows the dividend
    logic             is_rem;
    logic             load;
    logic [XLEN-1:0]  abs_dividend;
    logic [XLEN-1:0]  abs_divisor;
    logic [XLEN+1:0]  diff;         // Top bit is the borrow
    logic             q_bit;

    assign load = (state == DIV_IDLE) && start_i && ctrl_i.is_div;

    assign abs_dividend = dividend_neg ? (~remainder + 1'b1) : remainder;
    assign abs_divisor  = divisor_neg ? (~divisor + 1'b1) : divisor;

    // Trial subtract of the shifted partial remainder
    assign diff  = {1'b0, remainder, quotient[XLEN-1]} - {2'b00, divisor};
    assign q_bit = !diff[XLEN+1];

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= DIV_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                DIV_IDLE: if (load) state <= DIV_CHECK;
                DIV_CHECK: begin
                    step_cnt <= CNT_W'(XLEN - 1);
                    state    <= (divisor == '0) ? DIV_FIN : DIV_EXEC;
                end
                DIV_EXEC: begin
                    step_cnt <= step_cnt - 1'b1;
                    if (step_cnt == '0) state <= DIV_FIN;
                end
                default: state <= DIV_IDLE;  // DIV_FIN
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        case (state)
            DIV_IDLE: if (load) begin
                dividend_neg <= ctrl_i.is_signed && src1_i[XLEN-1];
                divisor_neg  <= ctrl_i.is_signed && src2_i[XLEN-1];
                quo_neg      <= ctrl_i.is_signed && (src1_i[XLEN-1] ^ src2_i[XLEN-1]);
                rem_neg      <= ctrl_i.is_signed && src1_i[XLEN-1];
                is_rem       <= ctrl_i.is_rem;
                divisor      <= src2_i;
                remainder    <= src1_i;  // Dividend parked here until the check
                quotient     <= '0;
            end
            DIV_CHECK: begin
                if (divisor == '0) begin
                    // All ones quotient, dividend stays as remainder
                    quotient <= '1;
                    quo_neg  <= 1'b0;
                    rem_neg  <= 1'b0;
                end else begin
                    divisor   <= abs_divisor;
                    remainder <= '0;
                    quotient  <= abs_dividend;
                end
            end
            DIV_EXEC: begin
                remainder <= q_bit ? diff[XLEN-1:0] : {remainder[XLEN-2:0], quotient[XLEN-1]};
                quotient  <= {quotient[XLEN-2:0], q_bit};
            end
            default: ;
        endcase
    end

    assign busy_o   = (state != DIV_IDLE);
    assign done_o   = (state == DIV_FIN);
    assign result_o = is_rem ? (rem_neg ? (~remainder + 1'b1) : remainder)
                             : (quo_neg ? (~quotient + 1'b1) : quotient);

    // Counter moves by one per step and is otherwise only loaded in the check
    a_cnt_exec_only: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (state != DIV_CHECK) |=>
            (step_cnt == $past(step_cnt) - CNT_W'($past(state) == DIV_EXEC))
    );

    a_done_pulse: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) done_o |=> !done_o
    );

endmodule

//--- rtl/rvm_pkg.sv
package rvm_pkg;

    // ------------------------------------------------------------------------
    // Operation code
    // ------------------------------------------------------------------------
    // Bit 2 picks the divider, clear means multiply
    typedef logic [2:0] funct3_t;

    typedef enum funct3_t {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } muldiv_op_e;

    // ------------------------------------------------------------------------
    // Unit controls
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic is_mul;       // Multiplier selected
        logic src1_signed;
        logic src2_signed;
        logic is_high;      // Upper product half
    } mul_ctrl_t;

    typedef struct packed {
        logic is_div;       // Divider selected
        logic is_signed;
        logic is_rem;       // Remainder instead of quotient
    } div_ctrl_t;

    // ------------------------------------------------------------------------
    // State machines
    // ------------------------------------------------------------------------
    typedef enum logic {
        MUL_IDLE,
        MUL_EXEC
    } mul_state_e;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_CHECK,
        DIV_EXEC,
        DIV_FIN
    } div_state_e;

endpackage

//--- rtl/rvm_unit.sv
`timescale 1ns/1ps

module rvm_unit #(
    parameter int XLEN = 32
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             cmd_valid_i,
    output logic             cmd_ready_o,
    input  rvm_pkg::funct3_t cmd_funct3_i,
    input  logic [XLEN-1:0]  cmd_src1_i,
    input  logic [XLEN-1:0]  cmd_src2_i,
    output logic             rsp_valid_o,
    input  logic             rsp_ready_i,
    output logic [XLEN-1:0]  rsp_result_o
);

    logic               start;
    logic [XLEN-1:0]    src1;
    logic [XLEN-1:0]    src2;
    rvm_pkg::mul_ctrl_t mul_ctrl;
    rvm_pkg::div_ctrl_t div_ctrl;
    logic               mul_busy;
    logic               mul_done;
    logic               div_busy;
    logic               div_done;
    logic [XLEN-1:0]    mul_result;
    logic [XLEN-1:0]    div_result;
    logic               pending;

    // ------------------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------------------
    muldiv_cmd_decode #(.XLEN(XLEN)) decode_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_funct3_i (cmd_funct3_i),
        .cmd_src1_i   (cmd_src1_i),
        .cmd_src2_i   (cmd_src2_i),
        .busy_i       (mul_busy || div_busy),
        .pending_i    (pending),
        .cmd_ready_o  (cmd_ready_o),
        .start_o      (start),
        .src1_o       (src1),
        .src2_o       (src2),
        .mul_ctrl_o   (mul_ctrl),
        .div_ctrl_o   (div_ctrl)
    );

    iter_multiplier #(.XLEN(XLEN)) mul_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .start_i  (start),
        .ctrl_i   (mul_ctrl),
        .src1_i   (src1),
        .src2_i   (src2),
        .busy_o   (mul_busy),
        .done_o   (mul_done),
        .result_o (mul_result)
    );

    restoring_divider #(.XLEN(XLEN)) div_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .start_i  (start),
        .ctrl_i   (div_ctrl),
        .src1_i   (src1),
        .src2_i   (src2),
        .busy_o   (div_busy),
        .done_o   (div_done),
        .result_o (div_result)
    );

    // ------------------------------------------------------------------------
    // Output side
    // ------------------------------------------------------------------------
    muldiv_response #(.XLEN(XLEN)) rsp_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .mul_done_i   (mul_done),
        .mul_result_i (mul_result),
        .div_done_i   (div_done),
        .div_result_i (div_result),
        .rsp_ready_i  (rsp_ready_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_result_o (rsp_result_o),
        .pending_o    (pending)
    );

endmodule

//--- rvm_unit.f
rtl/rvm_pkg.sv
rtl/muldiv_cmd_decode.sv
rtl/iter_multiplier.sv
rtl/restoring_divider.sv
rtl/muldiv_response.sv
rtl/rvm_unit.sv
test/tb_rvm_unit.sv

//--- test/tb_rvm_unit.sv
`timescale 1ns/1ps

module tb_rvm_unit
    import rvm_pkg::*;
();

    localparam int XLEN            = 32;
    localparam int N_MUL           = 240;
    localparam int N_DIV           = 240;
    localparam int N_CORNER        = 16;
    localparam int N_CMDS          = N_MUL + N_DIV + N_CORNER;
    localparam int MAX_LATENCY     = 40;
    localparam int WATCHDOG_CYCLES = N_CMDS * MAX_LATENCY + 500;

    logic            clk_i;
    logic            rst_n_i;
    logic            cmd_valid_i;
    logic            cmd_ready_o;
    logic [2:0]      cmd_funct3_i;
    logic [XLEN-1:0] cmd_src1_i;
    logic [XLEN-1:0] cmd_src2_i;
    logic            rsp_valid_o;
    logic            rsp_ready_i;
    logic [XLEN-1:0] rsp_result_o;

    integer          seed = 32'h4fd0;
    int              mismatch_count = 0;
    int              error_count = 0;
    int              cycle = 0;
    int              n_accepted = 0;
    int              n_responses = 0;
    logic [XLEN-1:0] exp_q[$];         // Expected results in acceptance order
    int              acc_cycle_q[$];   // Acceptance cycle per command
    logic            accepted_now;
    logic            hold_prev;
    logic            valid_prev;
    logic [XLEN-1:0] held_result;
    int              ready_stretch;
    logic            ready_level;

    rvm_unit #(.XLEN(XLEN)) dut_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_ready_o  (cmd_ready_o),
        .cmd_funct3_i (cmd_funct3_i),
        .cmd_src1_i   (cmd_src1_i),
        .cmd_src2_i   (cmd_src2_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .rsp_result_o (rsp_result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // Reference model in 64-bit arithmetic from the RISC-V M rules
    // ------------------------------------------------------------------------
    function automatic logic [XLEN-1:0] model_result(logic [2:0] f3, logic [XLEN-1:0] a,
                                                     logic [XLEN-1:0] b);
        longint      sa;
        longint      sb;
        logic [63:0] ext_a;
        logic [63:0] ext_b;
        logic [63:0] prod;
        logic [63:0] res;
        sa    = longint'($signed(a));
        sb    = longint'($signed(b));
        ext_a = (f3 == OP_MULH || f3 == OP_MULHSU) ? 64'(sa) : {32'd0, a};
        ext_b = (f3 == OP_MULH) ? 64'(sb) : {32'd0, b};
        prod  = ext_a * ext_b;  // Wraps mod 2^64, so the upper half is exact
        if (!f3[2]) begin
            res = (f3 == OP_MUL) ? prod : (prod >> 32);
        end else if (b == '0) begin
            res = (f3 == OP_DIV || f3 == OP_DIVU) ? 64'hFFFF_FFFF : {32'd0, a};
        end else begin
            case (f3)
                OP_DIV:  res = 64'(sa / sb);  // Truncates toward zero
                OP_DIVU: res = {32'd0, a} / {32'd0, b};
                OP_REM:  res = 64'(sa % sb);  // Sign of the dividend
                default: res = {32'd0, a} % {32'd0, b};
            endcase
        end
        return res[XLEN-1:0];
    endfunction

    function automatic logic [XLEN-1:0] rand_operand();
        logic [XLEN-1:0] r;
        r = $random(seed);
        case ($random(seed) & 7)
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            3:       return r & 32'hF;  // Small values
            default: return r;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // One clock cycle with handshakes at the coming edge and checks after it
    // ------------------------------------------------------------------------
    task automatic step();
        logic [XLEN-1:0] exp;
        if (ready_stretch == 0) begin
            ready_level   = ($random(seed) & 1) != 0;
            ready_stretch = 1 + ($random(seed) & 3);
        end
        ready_stretch--;
        rsp_ready_i = ready_level;

        accepted_now = cmd_valid_i && cmd_ready_o;
        if (accepted_now) begin
            exp_q.push_back(model_result(cmd_funct3_i, cmd_src1_i, cmd_src2_i));
            acc_cycle_q.push_back(cycle);
            n_accepted++;
        end
        if (rsp_valid_o && rsp_ready_i && exp_q.size() != 0) begin
            n_responses++;
            exp = exp_q.pop_front();
            void'(acc_cycle_q.pop_front());
            assert (rsp_result_o == exp) else begin
                mismatch_count++;
                $display("MISMATCH t=%0t rsp_result_o expected %08h got %08h",
                         $time, exp, rsp_result_o);
            end
        end
        hold_prev   = rsp_valid_o && !rsp_ready_i;
        held_result = rsp_result_o;
        valid_prev  = rsp_valid_o;

        @(negedge clk_i);
        cycle++;

        // Back-pressure must freeze the response
        if (hold_prev) begin
            assert (rsp_valid_o) else begin
                error_count++;
                $display("ERROR t=%0t rsp_valid_o dropped before the result was consumed",
                         $time);
            end
            assert (rsp_result_o == held_result) else begin
                mismatch_count++;
                $display("MISMATCH t=%0t rsp_result_o expected %08h got %08h",
                         $time, held_result, rsp_result_o);
            end
        end
        assert (exp_q.size() == 0 || !cmd_ready_o) else begin
            error_count++;
            $display("ERROR t=%0t cmd_ready_o high while a command is outstanding", $time);
        end
        if (rsp_valid_o && !valid_prev) begin
            assert (acc_cycle_q.size() != 0) else begin
                error_count++;
                $display("ERROR t=%0t response raised with no command outstanding", $time);
            end
            if (acc_cycle_q.size() != 0) begin
                assert (cycle - acc_cycle_q[0] <= MAX_LATENCY) else begin
                    error_count++;
                    $display("ERROR t=%0t response took %0d cycles", $time,
                             cycle - acc_cycle_q[0]);
                end
            end
        end
    endtask

    task automatic send_cmd(logic [2:0] f3, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        cmd_valid_i  = 1'b1;
        cmd_funct3_i = f3;
        cmd_src1_i   = a;
        cmd_src2_i   = b;
        do begin
            step();
        end while (!accepted_now);
        cmd_valid_i = 1'b0;
        cmd_src1_i  = $random(seed);  // Operands must already be registered
        cmd_src2_i  = $random(seed);
        repeat ($random(seed) & 1) step();
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [2:0] f3;
        rst_n_i       = 1'b0;
        cmd_valid_i   = 1'b0;
        cmd_funct3_i  = '0;
        cmd_src1_i    = '0;
        cmd_src2_i    = '0;
        rsp_ready_i   = 1'b0;
        ready_stretch = 0;
        ready_level   = 1'b0;
        accepted_now  = 1'b0;
        hold_prev     = 1'b0;
        valid_prev    = 1'b0;
        held_result   = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        assert (!rsp_valid_o && cmd_ready_o) else begin
            error_count++;
            $display("ERROR t=%0t unit not idle after reset", $time);
        end

        for (int i = 0; i < N_MUL; i++) begin
            send_cmd(3'($random(seed) & 3), rand_operand(), rand_operand());
        end
        for (int i = 0; i < N_DIV; i++) begin
            send_cmd(3'(4 + ($random(seed) & 3)), rand_operand(), rand_operand());
        end

        // Zero divisor, signed overflow, extreme products
        for (int k = 0; k < 4; k++) begin
            f3 = 3'(4 + k);
            send_cmd(f3, rand_operand(), '0);
            send_cmd(f3, 32'h8000_0000, 32'hFFFF_FFFF);
            send_cmd(f3, '0, '0);
            send_cmd(3'(k), 32'h8000_0000, 32'h8000_0000);
        end

        while (exp_q.size() != 0) step();
        repeat (4) step();
        assert (n_accepted == N_CMDS && n_responses == n_accepted) else begin
            error_count++;
            $display("ERROR accepted %0d commands but saw %0d responses",
                     n_accepted, n_responses);
        end

        $display("Summary: %0d commands, %0d responses, %0d mismatches, %0d other errors",
                 n_accepted, n_responses, mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the command count
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        error_count++;
        $display("ERROR t=%0t watchdog expired with %0d commands outstanding",
                 $time, exp_q.size());
        $display("Summary: %0d commands, %0d responses, %0d mismatches, %0d other errors",
                 n_accepted, n_responses, mismatch_count, error_count);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
